/* common/synth_settings.svh */
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// Voice count, one item per voice per sweep
`define NUM_VOICES 4

// Phase accumulator width
`define PHASE_W 32

// Signed audio sample width
`define SAMPLE_W 16

// Global amplitude width
`define AMP_W 8

// Right shift after the amplitude multiply
`define AMP_SHIFT 8

// System clocks per half period of the I2S bit clock
`define SCLK_DIV 2

`endif

/* common/synthPkg.sv */
`include "synth_settings.svh"

package synthPkg;

	// ========================================================================
	// Shared synthesizer types
	// ========================================================================

	// Unsigned phase, wraps modulo 2^PHASE_W
	typedef logic [`PHASE_W-1:0] phaseT;

	// Two's complement audio sample
	typedef logic signed [`SAMPLE_W-1:0] sampleT;

	// Voice number
	typedef logic [$clog2(`NUM_VOICES)-1:0] voiceIdxT;

	// Waveform select, code 0 is the reset default
	typedef enum logic [1:0] {
		WAVE_SAW      = 2'd0,
		WAVE_SQUARE   = 2'd1,
		WAVE_TRIANGLE = 2'd2,
		WAVE_OFF      = 2'd3
	} waveSelT;

	// Unsigned global amplitude
	typedef logic [`AMP_W-1:0] ampT;

endpackage

/* common/voiceBus.sv */
`timescale 1ns/1ps

interface voiceBus;
	import synthPkg::*;

	// One voice item, a single-cycle strobe
	logic     valid;
	voiceIdxT voice;
	phaseT    phase;
	waveSelT  wave;
	sampleT   sample;
	// Marks the final voice of a sweep
	logic     last;

	// Producer side, the sequencer or the shaper output stage
	modport seqSrc (output valid, voice, phase, wave, last, sample);

	// Shaper input side, sample here is the unregistered shaped value
	modport shaperPort (input valid, voice, phase, wave, last, output sample);

	// Mixer only needs the shaped sample and framing
	modport mixSink (input valid, sample, last);

endinterface

/* voice/voiceSequencer.sv */
`timescale 1ns/1ps
`include "synth_settings.svh"

module voiceSequencer (
	input  logic               MAX10_CLK2_50,
	input  logic               arstN,
	input  logic               sampleTick,
	input  logic               cfgWrite,
	input  synthPkg::voiceIdxT cfgVoice,
	input  synthPkg::phaseT    cfgIncr,
	input  synthPkg::waveSelT  cfgWave,
	voiceBus.seqSrc            seqBus
);
	import synthPkg::*;

	localparam voiceIdxT LAST_VOICE = voiceIdxT'(`NUM_VOICES - 1);

	// Per-voice state
	phaseT    incrReg  [`NUM_VOICES];
	waveSelT  waveReg  [`NUM_VOICES];
	phaseT    phaseReg [`NUM_VOICES];

	// Sweep control
	logic     busy;
	voiceIdxT sweepCnt;

	// ========================================================================
	// Item output
	// ========================================================================

	// Item carries the phase held before this sweep's update
	assign seqBus.valid = busy;
	assign seqBus.voice = sweepCnt;
	assign seqBus.phase = phaseReg[sweepCnt];
	assign seqBus.wave  = waveReg[sweepCnt];
	assign seqBus.last  = busy && (sweepCnt == LAST_VOICE);

	// ========================================================================
	// Sweep and phase update
	// ========================================================================

	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			busy     <= 1'b0;
			sweepCnt <= '0;
			for (int v = 0; v < `NUM_VOICES; v++) begin
				incrReg[v]  <= '0;
				waveReg[v]  <= WAVE_SAW;
				phaseReg[v] <= '0;
			end
		end else begin
			if (busy) begin
				// Advance the voice just emitted, wraps mod 2^32
				phaseReg[sweepCnt] <= phaseReg[sweepCnt] + incrReg[sweepCnt];
				sweepCnt           <= sweepCnt + 1'b1;
				if (sweepCnt == LAST_VOICE) begin
					busy <= 1'b0;
				end
			end else if (sampleTick) begin
				// Ticks while busy fall through and are dropped
				busy     <= 1'b1;
				sweepCnt <= '0;
			end

			// Config write wins over the phase update of the same voice
			if (cfgWrite) begin
				incrReg[cfgVoice]  <= cfgIncr;
				waveReg[cfgVoice]  <= cfgWave;
				phaseReg[cfgVoice] <= '0;
			end
		end
	end

endmodule

/* voice/waveShaper.sv */
`timescale 1ns/1ps
`include "synth_settings.svh"

module waveShaper (
	input  logic          MAX10_CLK2_50,
	input  logic          arstN,
	voiceBus.shaperPort   seqBus,
	voiceBus.seqSrc       shapeBus
);
	import synthPkg::*;

	localparam sampleT SQ_HIGH = {1'b0, {(`SAMPLE_W-1){1'b1}}};
	localparam sampleT SQ_LOW  = {1'b1, {(`SAMPLE_W-2){1'b0}}, 1'b1};

	// Top phase bits
	logic [`SAMPLE_W-1:0] p;
	// Phase bits below the MSB folded on the second half cycle
	logic [`SAMPLE_W-1:0] triFold;

	assign p       = seqBus.phase[`PHASE_W-1 -: `SAMPLE_W];
	assign triFold = seqBus.phase[`PHASE_W-1] ? ~seqBus.phase[`PHASE_W-2 -: `SAMPLE_W]
	                                          :  seqBus.phase[`PHASE_W-2 -: `SAMPLE_W];

	// ========================================================================
	// Combinational shaping
	// ========================================================================

	always_comb begin
		case (seqBus.wave)
			// Offset binary to two's complement
			WAVE_SAW:      seqBus.sample = sampleT'({~p[`SAMPLE_W-1], p[`SAMPLE_W-2:0]});
			// Symmetric full scale
			WAVE_SQUARE:   seqBus.sample = p[`SAMPLE_W-1] ? SQ_LOW : SQ_HIGH;
			WAVE_TRIANGLE: seqBus.sample = sampleT'({~triFold[`SAMPLE_W-1],
			                                         triFold[`SAMPLE_W-2:0]});
			// WAVE_OFF
			default:       seqBus.sample = '0;
		endcase
	end

	// Valid and last of the shaped item
	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			shapeBus.valid <= 1'b0;
			shapeBus.last  <= 1'b0;
		end else begin
			shapeBus.valid <= seqBus.valid;
			shapeBus.last  <= seqBus.valid & seqBus.last;
		end
	end

	// Sample captured with each item
	always_ff @(posedge MAX10_CLK2_50) begin
		if (seqBus.valid) begin
			shapeBus.sample <= seqBus.sample;
		end
	end

endmodule

/* src/voiceMixer.sv */
`timescale 1ns/1ps
`include "synth_settings.svh"

module voiceMixer (
	input  logic             MAX10_CLK2_50,
	input  logic             arstN,
	input  synthPkg::ampT    amplitude,
	voiceBus.mixSink         shapeBus,
	output synthPkg::sampleT mixSample,
	output logic             mixValid
);
	import synthPkg::*;

	// Product keeps a sign bit for the unsigned amplitude
	localparam int PROD_W = `SAMPLE_W + `AMP_W + 1;
	// Headroom for the whole sweep
	localparam int ACC_W  = PROD_W + $clog2(`NUM_VOICES);

	localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(2 ** (`SAMPLE_W - 1) - 1);
	localparam logic signed [ACC_W-1:0] SAT_MIN = ACC_W'(-(2 ** (`SAMPLE_W - 1)));

	logic signed [PROD_W-1:0] product;
	logic signed [PROD_W-1:0] scaled;
	logic signed [ACC_W-1:0]  accReg;
	logic signed [ACC_W-1:0]  accNext;
	sampleT                   satSample;

	// ========================================================================
	// Scale and accumulate
	// ========================================================================

	assign product = shapeBus.sample * $signed({1'b0, amplitude});
	// Arithmetic shift, rounds toward minus infinity
	assign scaled  = product >>> `AMP_SHIFT;
	assign accNext = accReg + ACC_W'(scaled);

	// Clip to the sample range
	always_comb begin
		if (accNext > SAT_MAX) begin
			satSample = SAT_MAX[`SAMPLE_W-1:0];
		end else if (accNext < SAT_MIN) begin
			satSample = SAT_MIN[`SAMPLE_W-1:0];
		end else begin
			satSample = accNext[`SAMPLE_W-1:0];
		end
	end

	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			accReg    <= '0;
			mixSample <= '0;
			mixValid  <= 1'b0;
		end else begin
			mixValid <= 1'b0;
			if (shapeBus.valid) begin
				if (shapeBus.last) begin
					// Sweep done, publish and restart from zero
					mixSample <= satSample;
					mixValid  <= 1'b1;
					accReg    <= '0;
				end else begin
					accReg <= accNext;
				end
			end
		end
	end

endmodule

/* src/i2sTransmitter.sv */
`timescale 1ns/1ps
`include "synth_settings.svh"

module i2sTransmitter (
	input  logic             MAX10_CLK2_50,
	input  logic             arstN,
	input  synthPkg::sampleT mixSample,
	output logic             bclk,
	output logic             lrclk,
	output logic             sdata
);
	import synthPkg::*;

	localparam int DIV_W = ($clog2(`SCLK_DIV) > 0) ? $clog2(`SCLK_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCLK_DIV - 1);

	// Two words per frame
	localparam int BIT_W = $clog2(2 * `SAMPLE_W);
	localparam logic [BIT_W-1:0] FRAME_LAST = BIT_W'(2 * `SAMPLE_W - 1);
	localparam logic [BIT_W-1:0] RIGHT_FIRST = BIT_W'(`SAMPLE_W);

	logic [DIV_W-1:0] divCnt;
	// Index of the bit now on sdata
	logic [BIT_W-1:0] bitCnt;
	logic [BIT_W-1:0] nextBit;
	logic             bclkFall;
	sampleT           shiftReg;
	// Frame sample, reused for the right word
	sampleT           wordSample;

	assign bclkFall = (divCnt == DIV_LAST) && bclk;
	assign nextBit  = (bitCnt == FRAME_LAST) ? '0 : bitCnt + 1'b1;

	// ========================================================================
	// Bit clock divider
	// ========================================================================

	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			divCnt <= '0;
			bclk   <= 1'b0;
		end else if (divCnt == DIV_LAST) begin
			divCnt <= '0;
			bclk   <= ~bclk;
		end else begin
			divCnt <= divCnt + 1'b1;
		end
	end

	// ========================================================================
	// Frame sequencing, all changes on the falling edge of bclk
	// ========================================================================

	always_ff @(posedge MAX10_CLK2_50 or negedge arstN) begin
		if (!arstN) begin
			// First falling edge opens a frame
			bitCnt <= FRAME_LAST;
			lrclk  <= 1'b0;
			sdata  <= 1'b0;
		end else if (bclkFall) begin
			bitCnt <= nextBit;
			if (nextBit == '0) begin
				// Left word, latch newest sample
				lrclk <= 1'b0;
				sdata <= mixSample[`SAMPLE_W-1];
			end else if (nextBit == RIGHT_FIRST) begin
				lrclk <= 1'b1;
				sdata <= wordSample[`SAMPLE_W-1];
			end else begin
				sdata <= shiftReg[`SAMPLE_W-1];
			end
		end
	end

	// Shift data, MSB first
	always_ff @(posedge MAX10_CLK2_50) begin
		if (bclkFall) begin
			if (nextBit == '0) begin
				wordSample <= mixSample;
				shiftReg   <= mixSample <<< 1;
			end else if (nextBit == RIGHT_FIRST) begin
				shiftReg <= wordSample <<< 1;
			end else begin
				shiftReg <= shiftReg <<< 1;
			end
		end
	end

endmodule

/* src/fpgaSynth.sv */
`timescale 1ns/1ps

module fpgaSynth (
	input  logic               MAX10_CLK2_50,
	input  logic               arstN,
	input  logic               sampleTick,
	input  logic               cfgWrite,
	input  synthPkg::voiceIdxT cfgVoice,
	input  synthPkg::phaseT    cfgIncr,
	input  synthPkg::waveSelT  cfgWave,
	input  synthPkg::ampT      amplitude,
	output synthPkg::sampleT   mixSample,
	output logic               mixValid,
	output logic               bclk,
	output logic               lrclk,
	output logic               sdata
);

	// ========================================================================
	// Voice pipeline buses
	// ========================================================================

	// Sequencer to shaper
	voiceBus seqBus ();
	// Shaper to mixer
	voiceBus shapeBus ();

	// Phase accumulators and per-tick sweep
	voiceSequencer voiceSequencer_i (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.sampleTick    (sampleTick),
		.cfgWrite      (cfgWrite),
		.cfgVoice      (cfgVoice),
		.cfgIncr       (cfgIncr),
		.cfgWave       (cfgWave),
		.seqBus        (seqBus)
	);

	// Phase to sample, one cycle
	waveShaper waveShaper_i (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.seqBus        (seqBus),
		.shapeBus      (shapeBus)
	);

	// Scale, sum and clip one sweep
	voiceMixer voiceMixer_i (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.amplitude     (amplitude),
		.shapeBus      (shapeBus),
		.mixSample     (mixSample),
		.mixValid      (mixValid)
	);

	// Codec serial output, free running
	i2sTransmitter i2sTransmitter_i (
		.MAX10_CLK2_50 (MAX10_CLK2_50),
		.arstN         (arstN),
		.mixSample     (mixSample),
		.bclk          (bclk),
		.lrclk         (lrclk),
		.sdata         (sdata)
	);

endmodule

/* dv/fpgaSynthTb.sv */
`timescale 1ns/1ps
`include "synth_settings.svh"

module fpgaSynthTb;
	import synthPkg::*;

	// ========================================================================
	// Run length
	// ========================================================================

	localparam int ROUNDS       = 6;
	localparam int ROUND_TICKS  = 3;
	// Random rounds plus saturation, config and ignored-tick cases
	localparam int NUM_TICKS    = ROUNDS * ROUND_TICKS + 8;
	localparam int NUM_FRAMES   = 4;
	localparam int FRAME_BITS   = 2 * `SAMPLE_W;
	localparam int FRAME_CYCLES = FRAME_BITS * 2 * `SCLK_DIV;
	localparam int WATCHDOG     = NUM_TICKS * 10 + NUM_FRAMES * 140 + 200;

	logic     MAX10_CLK2_50;
	logic     arstN;
	logic     sampleTick;
	logic     cfgWrite;
	voiceIdxT cfgVoice;
	phaseT    cfgIncr;
	waveSelT  cfgWave;
	ampT      amplitude;
	sampleT   mixSample;
	logic     mixValid;
	logic     bclk;
	logic     lrclk;
	logic     sdata;

	integer   seed;
	int       mismatches = 0;
	int       failures = 0;

	fpgaSynth dut_i (.*);

	initial begin
		MAX10_CLK2_50 = 1'b0;
		forever #2 MAX10_CLK2_50 = ~MAX10_CLK2_50;
	end

	// ========================================================================
	// Reference model stepped on each rising clock edge
	// ========================================================================

	phaseT    mIncr  [`NUM_VOICES];
	waveSelT  mWave  [`NUM_VOICES];
	phaseT    mPhase [`NUM_VOICES];
	ampT      mAmp;
	logic     mBusy;
	int       mCnt;
	int       mAcc;
	logic     pendValid;
	sampleT   pendSample;
	logic     expValid;
	sampleT   expSample;

	// Top phase bits as offset binary recentred around zero
	function automatic int shapeSample(input phaseT ph, input waveSelT w);
		logic [15:0] top;
		logic [15:0] fold;
		top  = ph[31:16];
		fold = ph[31] ? ~ph[30:15] : ph[30:15];
		case (w)
			WAVE_SAW:      return int'(top) - 32768;
			WAVE_SQUARE:   return ph[31] ? -32767 : 32767;
			WAVE_TRIANGLE: return int'(fold) - 32768;
			default:       return 0;
		endcase
	endfunction

	function automatic sampleT clip(input int sum);
		if (sum > 32767)
			return 16'sh7FFF;
		if (sum < -32768)
			return 16'sh8000;
		return sampleT'(sum);
	endfunction

	always @(posedge MAX10_CLK2_50) begin
		if (!arstN) begin
			for (int v = 0; v < `NUM_VOICES; v++) begin
				mIncr[v]  = '0;
				mWave[v]  = WAVE_SAW;
				mPhase[v] = '0;
			end
			mAmp      = '0;
			mBusy     = 1'b0;
			mCnt      = 0;
			mAcc      = 0;
			pendValid = 1'b0;
			expValid  = 1'b0;
			expSample = '0;
		end else begin
			// Mixed result shows one cycle after the last voice
			expValid = pendValid;
			if (pendValid)
				expSample = pendSample;
			pendValid = 1'b0;
			if (mBusy) begin
				// Item uses the phase before this voice advances
				mAcc = mAcc + ((shapeSample(mPhase[mCnt], mWave[mCnt]) * int'(mAmp))
				       >>> `AMP_SHIFT);
				mPhase[mCnt] = mPhase[mCnt] + mIncr[mCnt];
				if (mCnt == `NUM_VOICES - 1) begin
					pendValid  = 1'b1;
					pendSample = clip(mAcc);
					mAcc       = 0;
					mBusy      = 1'b0;
				end
				mCnt++;
			end else if (sampleTick) begin
				mBusy = 1'b1;
				mCnt  = 0;
				mAmp  = amplitude;
			end
			// Config write wins and the phase restarts at zero
			if (cfgWrite) begin
				mIncr[cfgVoice]  = cfgIncr;
				mWave[cfgVoice]  = cfgWave;
				mPhase[cfgVoice] = '0;
			end
		end
	end

	// ========================================================================
	// I2S receiver
	// ========================================================================

	sampleT   prevMix;
	int       fallCnt = 0;
	int       bitIdx = 0;
	logic     framing = 1'b0;
	logic     lrOk = 1'b1;
	sampleT   frameExp;
	sampleT   leftWord;
	sampleT   rightWord;
	sampleT   doneExp = '0;
	sampleT   doneLeft = '0;
	sampleT   doneRight = '0;
	logic     doneLrOk = 1'b1;
	int       framesChecked = 0;

	// Model sample held before the edge that may start a frame
	always @(negedge MAX10_CLK2_50)
		prevMix = expSample;

	always @(bclk) begin
		if (arstN && bclk === 1'b0) begin
			fallCnt++;
			// First fall after reset opens frame one
			if (fallCnt % FRAME_BITS == 1) begin
				frameExp = prevMix;
				bitIdx   = 0;
				lrOk     = 1'b1;
				framing  = 1'b1;
			end
		end else if (arstN && bclk === 1'b1 && framing) begin
			if (bitIdx < `SAMPLE_W)
				leftWord = {leftWord[`SAMPLE_W-2:0], sdata};
			else
				rightWord = {rightWord[`SAMPLE_W-2:0], sdata};
			if (lrclk !== (bitIdx >= `SAMPLE_W))
				lrOk = 1'b0;
			bitIdx++;
			if (bitIdx == FRAME_BITS) begin
				doneExp   = frameExp;
				doneLeft  = leftWord;
				doneRight = rightWord;
				doneLrOk  = lrOk;
				framesChecked++;
			end
		end
	end

	// ========================================================================
	// Checks at the falling clock edge
	// ========================================================================

	resetCheck: assert property (@(negedge MAX10_CLK2_50)
		!arstN |-> (!mixValid && !bclk && !lrclk && !sdata && mixSample == '0))
	else begin
		failures++;
		$display("Outputs not at their reset values at t=%0t", $time);
	end

	validCheck: assert property (@(negedge MAX10_CLK2_50) disable iff (!arstN)
		mixValid == expValid)
	else begin
		mismatches++;
		$display("MISMATCH t=%0t mixValid expected=%0b actual=%0b", $time, expValid, mixValid);
	end

	sampleCheck: assert property (@(negedge MAX10_CLK2_50) disable iff (!arstN)
		mixSample == expSample)
	else begin
		mismatches++;
		$display("MISMATCH t=%0t mixSample expected=%h actual=%h", $time, expSample, mixSample);
	end

	leftCheck: assert property (@(negedge MAX10_CLK2_50) disable iff (!arstN)
		doneLeft == doneExp)
	else begin
		mismatches++;
		$display("MISMATCH t=%0t i2sLeft expected=%h actual=%h", $time, doneExp, doneLeft);
	end

	rightCheck: assert property (@(negedge MAX10_CLK2_50) disable iff (!arstN)
		doneRight == doneExp)
	else begin
		mismatches++;
		$display("MISMATCH t=%0t i2sRight expected=%h actual=%h", $time, doneExp, doneRight);
	end

	lrCheck: assert property (@(negedge MAX10_CLK2_50) disable iff (!arstN) doneLrOk)
	else begin
		failures++;
		$display("lrclk did not follow the word being sent, t=%0t", $time);
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic nextCycle();
		@(posedge MAX10_CLK2_50);
		#1;
	endtask

	task automatic writeVoice(input int v, input phaseT incr, input waveSelT w);
		cfgWrite = 1'b1;
		cfgVoice = voiceIdxT'(v);
		cfgIncr  = incr;
		cfgWave  = w;
		nextCycle();
		cfgWrite = 1'b0;
	endtask

	task automatic pulseTick(input ampT amp);
		amplitude  = amp;
		sampleTick = 1'b1;
		nextCycle();
		sampleTick = 1'b0;
	endtask

	// Wait for the mixed sample and leave the tick gap
	task automatic awaitMix();
		int n;
		n = 0;
		while (!mixValid && n < 12) begin
			nextCycle();
			n++;
		end
		if (!mixValid) begin
			failures++;
			$display("No mixValid within 12 cycles of a sampleTick, t=%0t", $time);
		end
		repeat (3) nextCycle();
	endtask

	initial begin
		ampT amp;
		seed       = 32'hcfd9;
		arstN      = 1'b0;
		sampleTick = 1'b0;
		cfgWrite   = 1'b0;
		cfgVoice   = '0;
		cfgIncr    = '0;
		cfgWave    = WAVE_SAW;
		amplitude  = '0;
		repeat (5) @(posedge MAX10_CLK2_50);
		#1 arstN = 1'b1;
		nextCycle();

		// Random increments with every waveform code rotating over the voices
		for (int r = 0; r < ROUNDS; r++) begin
			for (int v = 0; v < `NUM_VOICES; v++)
				writeVoice(v, phaseT'($random(seed)), waveSelT'((v + r) % 4));
			for (int t = 0; t < ROUND_TICKS; t++) begin
				pulseTick(ampT'($random(seed)));
				awaitMix();
			end
		end

		// Four full-scale squares clip high and then low
		for (int v = 0; v < `NUM_VOICES; v++)
			writeVoice(v, 32'h8000_0000, WAVE_SQUARE);
		pulseTick(8'd255);
		awaitMix();
		pulseTick(8'd255);
		awaitMix();

		// Restart voice 0 from phase zero and then silence voice 1
		writeVoice(0, 32'h0123_4567, WAVE_SAW);
		pulseTick(8'd200);
		awaitMix();
		writeVoice(1, 32'h1000_0000, WAVE_OFF);
		pulseTick(8'd200);
		awaitMix();
		// Write landing inside a sweep
		pulseTick(ampT'($random(seed)));
		writeVoice(3, 32'h4000_0000, WAVE_TRIANGLE);
		awaitMix();

		// Second tick two cycles in is dropped
		amp = ampT'($random(seed));
		pulseTick(amp);
		nextCycle();
		pulseTick(amp);
		awaitMix();
		repeat (8) nextCycle();
		// Next sweep shows the phases moved by a single increment
		pulseTick(8'd128);
		awaitMix();

		// Let the serial side run whole frames
		repeat (NUM_FRAMES * FRAME_CYCLES) nextCycle();
		if (framesChecked == 0) begin
			failures++;
			$display("No complete I2S frame was received");
		end

		$display("Errors: %0d mismatches, %0d other failures, %0d I2S frames checked",
		         mismatches, failures, framesChecked);
		if (mismatches == 0 && failures == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Bound on the whole run
	initial begin
		repeat (WATCHDOG) @(posedge MAX10_CLK2_50);
		$display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* fpgaSynth.f */
+incdir+common
common/synthPkg.sv
common/voiceBus.sv
voice/voiceSequencer.sv
voice/waveShaper.sv
src/voiceMixer.sv
src/i2sTransmitter.sv
src/fpgaSynth.sv
dv/fpgaSynthTb.sv

/* Makefile */
# Verilator flow for the four-voice synthesizer

VERILATOR ?= verilator
TB_TOP    ?= fpgaSynthTb
RTL_TOP   ?= fpgaSynth
FILELIST  ?= fpgaSynth.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
